/* rtl/soc_apb_pkg.sv */
`default_nettype none

package soc_apb_pkg;

  // device apb bus widths
  localparam int apb_addr_w = 32;
  localparam int apb_data_w = 32;

  // peripheral slot field in paddr, one 4 KiB window per slot
  localparam int slot_lsb = 12;
  localparam int slot_w   = 2;

  // slot codes, code 3 is unused
  localparam logic [slot_w-1:0] slot_spi  = 2'd0;
  localparam logic [slot_w-1:0] slot_uart = 2'd1;
  localparam logic [slot_w-1:0] slot_pll  = 2'd2;

  // word index inside a slot starts at the 32-bit boundary
  localparam int word_lsb = 2;

endpackage

`default_nettype wire

/* rtl/pll_cfg_pkg.sv */
`default_nettype none

package pll_cfg_pkg;

  // one full pll configuration word
  localparam int pll_cfg_w = 64;

  // word index selecting a half of cfg1 or cfg2
  localparam int pll_word_w = 2;

  // lo halves go through the staging register
  localparam logic [pll_word_w-1:0] word_cfg1_lo = 2'd0;
  localparam logic [pll_word_w-1:0] word_cfg1_hi = 2'd1;
  localparam logic [pll_word_w-1:0] word_cfg2_lo = 2'd2;
  localparam logic [pll_word_w-1:0] word_cfg2_hi = 2'd3;

endpackage

`default_nettype wire

/* rtl/apb_slot_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module apb_slot_decode (
  input  wire logic [soc_apb_pkg::apb_addr_w-1:0] paddr,
  input  wire logic                               psel,
  input  wire logic                               penable,
  input  wire logic                               pwrite,
  input  wire logic [soc_apb_pkg::apb_data_w-1:0] pwdata,
  input  wire logic [soc_apb_pkg::apb_data_w-1:0] reg_rdata,
  output logic                                    pready,
  output logic                                    pslverr,
  output logic      [soc_apb_pkg::apb_data_w-1:0] prdata,
  output logic                                    reg_wr,
  output logic      [pll_cfg_pkg::pll_word_w-1:0] reg_word,
  output logic      [soc_apb_pkg::apb_data_w-1:0] reg_wdata
);

  import soc_apb_pkg::*;
  import pll_cfg_pkg::*;

  logic [slot_w-1:0] slot;
  logic              access;
  logic              pll_hit;

  assign slot   = paddr[slot_lsb +: slot_w];
  // second cycle of the transfer, zero wait states
  assign access = psel && penable;

  always_comb begin
    case (slot)
      slot_pll: pll_hit = 1'b1;
      // spi, uart and the unused slot are not present in this block
      default:  pll_hit = 1'b0;
    endcase
  end

  assign pready  = access;
  assign pslverr = access && !pll_hit;

  assign reg_wr    = access && pwrite && pll_hit;
  assign reg_word  = paddr[word_lsb +: pll_word_w];
  assign reg_wdata = pwdata;

  // error slots and writes return zero data
  assign prdata = (access && !pwrite && pll_hit) ? reg_rdata : '0;

endmodule

`default_nettype wire

/* rtl/pll_cfg_regs.sv */
`default_nettype none
`timescale 1ns/100ps

module pll_cfg_regs (
  input  wire logic                                   dev_clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   reg_wr,
  input  wire logic [pll_cfg_pkg::pll_word_w-1:0]     reg_word,
  input  wire logic [pll_cfg_pkg::pll_cfg_w/2-1:0]    reg_wdata,
  output logic      [pll_cfg_pkg::pll_cfg_w/2-1:0]    reg_rdata,
  output logic      [pll_cfg_pkg::pll_cfg_w-1:0]      pll_cfg_1,
  output logic      [pll_cfg_pkg::pll_cfg_w-1:0]      pll_cfg_2,
  output logic                                        pll_cfg_ctr
);

  import pll_cfg_pkg::*;

  // low half waiting for its hi write
  logic [pll_cfg_w/2-1:0] pll_stage;

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      pll_stage <= '0;
      pll_cfg_1 <= '0;
      pll_cfg_2 <= '0;
    end else if (reg_wr) begin
      case (reg_word)
        word_cfg1_lo: pll_stage <= reg_wdata;
        word_cfg1_hi: pll_cfg_1 <= {reg_wdata, pll_stage};
        word_cfg2_lo: pll_stage <= reg_wdata;
        word_cfg2_hi: pll_cfg_2 <= {reg_wdata, pll_stage};
        default: ;
      endcase
    end
  end

  // config valid once both words are programmed
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      pll_cfg_ctr <= 1'b0;
    end else begin
      pll_cfg_ctr <= (pll_cfg_1 != '0) && (pll_cfg_2 != '0);
    end
  end

  // readback of the live words, never the staging value
  always_comb begin
    case (reg_word)
      word_cfg1_lo: reg_rdata = pll_cfg_1[pll_cfg_w/2-1:0];
      word_cfg1_hi: reg_rdata = pll_cfg_1[pll_cfg_w-1:pll_cfg_w/2];
      word_cfg2_lo: reg_rdata = pll_cfg_2[pll_cfg_w/2-1:0];
      word_cfg2_hi: reg_rdata = pll_cfg_2[pll_cfg_w-1:pll_cfg_w/2];
      default:      reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/core_clk_rst.sv */
`default_nettype none
`timescale 1ns/100ps

module core_clk_rst (
  input  wire logic dev_clk,
  input  wire logic rst_n,
  output logic      core_rst_n,
  output logic      core_clk_out
);

  logic       rst_s1;
  logic       rst_s2;
  logic [1:0] div_cnt;

  // async assert, release on the third edge
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_s1     <= 1'b0;
      rst_s2     <= 1'b0;
      core_rst_n <= 1'b0;
    end else begin
      rst_s1     <= 1'b1;
      rst_s2     <= rst_s1;
      core_rst_n <= rst_s2;
    end
  end

  // core clock is dev_clk here, monitor at div 8
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt      <= 2'd0;
      core_clk_out <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 2'd1;
      if (div_cnt == 2'd3) begin
        core_clk_out <= ~core_clk_out;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/soc_ctrl_top.sv */
`default_nettype none
`timescale 1ns/100ps

module soc_ctrl_top (
  input  wire logic                               dev_clk,
  input  wire logic                               rst_n,
  input  wire logic [soc_apb_pkg::apb_addr_w-1:0] paddr,
  input  wire logic                               psel,
  input  wire logic                               penable,
  input  wire logic                               pwrite,
  input  wire logic [soc_apb_pkg::apb_data_w-1:0] pwdata,
  output wire logic                               pready,
  output wire logic [soc_apb_pkg::apb_data_w-1:0] prdata,
  output wire logic                               pslverr,
  output wire logic [pll_cfg_pkg::pll_cfg_w-1:0]  pll_cfg_1,
  output wire logic [pll_cfg_pkg::pll_cfg_w-1:0]  pll_cfg_2,
  output wire logic                               pll_cfg_ctr,
  output wire logic                               core_rst_n,
  output wire logic                               core_clk_out
);

  import soc_apb_pkg::*;
  import pll_cfg_pkg::*;

  // register access from the pll slot
  wire logic                  reg_wr;
  wire logic [pll_word_w-1:0] reg_word;
  wire logic [apb_data_w-1:0] reg_wdata;
  wire logic [apb_data_w-1:0] reg_rdata;

  apb_slot_decode u_decode (
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .reg_rdata (reg_rdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .prdata    (prdata),
    .reg_wr    (reg_wr),
    .reg_word  (reg_word),
    .reg_wdata (reg_wdata)
  );

  pll_cfg_regs u_pll_regs (
    .dev_clk     (dev_clk),
    .rst_n       (rst_n),
    .reg_wr      (reg_wr),
    .reg_word    (reg_word),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .pll_cfg_1   (pll_cfg_1),
    .pll_cfg_2   (pll_cfg_2),
    .pll_cfg_ctr (pll_cfg_ctr)
  );

  core_clk_rst u_clk_rst (
    .dev_clk      (dev_clk),
    .rst_n        (rst_n),
    .core_rst_n   (core_rst_n),
    .core_clk_out (core_clk_out)
  );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen (
  output logic dev_clk,
  output logic rst_n
);

  localparam int half_period  = 50;
  localparam int reset_cycles = 8;

  initial begin
    dev_clk = 1'b0;
    forever #half_period dev_clk = ~dev_clk;
  end

  // release on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge dev_clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* dv/soc_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module soc_ctrl_tb;

  import soc_apb_pkg::*;
  import pll_cfg_pkg::*;

  localparam int n_entries      = 21;
  localparam int timeout_cycles = 8 + 3 * n_entries + 64;
  localparam logic [slot_w-1:0] slot_unused = 2'd3;

  logic                  dev_clk;
  logic                  rst_n;
  logic [apb_addr_w-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_data_w-1:0] pwdata;
  logic                  pready;
  logic [apb_data_w-1:0] prdata;
  logic                  pslverr;
  logic [pll_cfg_w-1:0]  pll_cfg_1;
  logic [pll_cfg_w-1:0]  pll_cfg_2;
  logic                  pll_cfg_ctr;
  logic                  core_rst_n;
  logic                  core_clk_out;

  // stimulus table and expected values
  logic                  tbl_wr     [n_entries];
  logic [slot_w-1:0]     tbl_slot   [n_entries];
  logic [pll_word_w-1:0] tbl_word   [n_entries];
  logic                  tbl_zero   [n_entries];
  logic [apb_data_w-1:0] tbl_data   [n_entries];
  logic [apb_data_w-1:0] exp_rdata  [n_entries];
  logic                  exp_err    [n_entries];
  logic [pll_cfg_w-1:0]  exp_cfg1   [n_entries];
  logic [pll_cfg_w-1:0]  exp_cfg2   [n_entries];
  logic                  exp_valid  [n_entries];

  int cycle_cnt = 0;

  tb_clk_gen u_clk_gen (
    .dev_clk (dev_clk),
    .rst_n   (rst_n)
  );

  soc_ctrl_top u_dut (
    .dev_clk      (dev_clk),
    .rst_n        (rst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .pready       (pready),
    .prdata       (prdata),
    .pslverr      (pslverr),
    .pll_cfg_1    (pll_cfg_1),
    .pll_cfg_2    (pll_cfg_2),
    .pll_cfg_ctr  (pll_cfg_ctr),
    .core_rst_n   (core_rst_n),
    .core_clk_out (core_clk_out)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_entry(input int idx, input logic wr, input logic [slot_w-1:0] slot,
                           input logic [pll_word_w-1:0] word, input logic zero);
    tbl_wr[idx]   = wr;
    tbl_slot[idx] = slot;
    tbl_word[idx] = word;
    tbl_zero[idx] = zero;
  endtask

  // reference model of the staging register and both words
  task automatic build_expected();
    logic [31:0] stage;
    logic [63:0] cfg1;
    logic [63:0] cfg2;
    int          i;
    stage = '0;
    cfg1  = '0;
    cfg2  = '0;
    for (i = 0; i < n_entries; i++) begin
      exp_valid[i] = (cfg1 != '0) && (cfg2 != '0);
      exp_err[i]   = (tbl_slot[i] != slot_pll);
      exp_rdata[i] = '0;
      if (!exp_err[i] && tbl_wr[i]) begin
        case (tbl_word[i])
          word_cfg1_hi: cfg1 = {tbl_data[i], stage};
          word_cfg2_hi: cfg2 = {tbl_data[i], stage};
          default:      stage = tbl_data[i];
        endcase
      end else if (!exp_err[i]) begin
        case (tbl_word[i])
          word_cfg1_lo: exp_rdata[i] = cfg1[31:0];
          word_cfg1_hi: exp_rdata[i] = cfg1[63:32];
          word_cfg2_lo: exp_rdata[i] = cfg2[31:0];
          default:      exp_rdata[i] = cfg2[63:32];
        endcase
      end
      exp_cfg1[i] = cfg1;
      exp_cfg2[i] = cfg2;
    end
  endtask

  task automatic check_reset_state(input string when);
    check_value(pll_cfg_1, 64'd0, {"pll_cfg_1 ", when});
    check_value(pll_cfg_2, 64'd0, {"pll_cfg_2 ", when});
    check_value(64'(pll_cfg_ctr), 64'd0, {"pll_cfg_ctr ", when});
    check_value(64'(core_clk_out), 64'd0, {"core_clk_out ", when});
    check_value(64'(pready), 64'd0, {"pready ", when});
    check_value(64'(pslverr), 64'd0, {"pslverr ", when});
    check_value(64'(core_rst_n), 64'd0, {"core_rst_n ", when});
  endtask

  // setup, access and one idle cycle per entry
  task automatic run_entry(input int i);
    logic [apb_addr_w-1:0] addr;
    addr = '0;
    addr[slot_lsb +: slot_w]     = tbl_slot[i];
    addr[word_lsb +: pll_word_w] = tbl_word[i];
    @(posedge dev_clk);
    paddr   <= addr;
    pwrite  <= tbl_wr[i];
    pwdata  <= tbl_data[i];
    psel    <= 1'b1;
    penable <= 1'b0;
    @(negedge dev_clk);
    check_value(64'(pready), 64'd0, $sformatf("pready in setup, entry %0d", i));
    check_value(64'(pll_cfg_ctr), 64'(exp_valid[i]),
                $sformatf("pll_cfg_ctr before entry %0d", i));
    @(posedge dev_clk);
    penable <= 1'b1;
    @(negedge dev_clk);
    check_value(64'(pready), 64'd1, $sformatf("pready, entry %0d", i));
    check_value(64'(pslverr), 64'(exp_err[i]), $sformatf("pslverr, entry %0d", i));
    check_value(64'(prdata), 64'(exp_rdata[i]), $sformatf("prdata, entry %0d", i));
    @(posedge dev_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(negedge dev_clk);
    check_value(pll_cfg_1, exp_cfg1[i], $sformatf("pll_cfg_1 after entry %0d", i));
    check_value(pll_cfg_2, exp_cfg2[i], $sformatf("pll_cfg_2 after entry %0d", i));
    // flag lags the words by one edge
    check_value(64'(pll_cfg_ctr), 64'(exp_valid[i]),
                $sformatf("pll_cfg_ctr right after entry %0d", i));
  endtask

  always @(posedge dev_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the test did not finish within %0d clock cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  initial begin
    logic [31:0] seed;
    int          i;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;

    // cfg1 pair then readback
    set_entry(0, 1'b1, slot_pll, word_cfg1_lo, 1'b0);
    set_entry(1, 1'b1, slot_pll, word_cfg1_hi, 1'b0);
    set_entry(2, 1'b0, slot_pll, word_cfg1_lo, 1'b0);
    set_entry(3, 1'b0, slot_pll, word_cfg1_hi, 1'b0);
    // cfg2 pair sets the valid flag
    set_entry(4, 1'b1, slot_pll, word_cfg2_lo, 1'b0);
    set_entry(5, 1'b1, slot_pll, word_cfg2_hi, 1'b0);
    set_entry(6, 1'b0, slot_pll, word_cfg2_lo, 1'b0);
    set_entry(7, 1'b0, slot_pll, word_cfg2_hi, 1'b0);
    // error slots must leave staging and words alone
    set_entry(8, 1'b1, slot_spi, word_cfg1_lo, 1'b0);
    set_entry(9, 1'b0, slot_spi, word_cfg1_lo, 1'b0);
    set_entry(10, 1'b1, slot_uart, word_cfg1_hi, 1'b0);
    set_entry(11, 1'b0, slot_uart, word_cfg2_lo, 1'b0);
    set_entry(12, 1'b1, slot_unused, word_cfg2_hi, 1'b0);
    set_entry(13, 1'b0, slot_unused, word_cfg1_hi, 1'b0);
    // hi write alone reuses the cfg2 low half still staged
    set_entry(14, 1'b1, slot_pll, word_cfg1_hi, 1'b0);
    set_entry(15, 1'b0, slot_pll, word_cfg1_lo, 1'b0);
    set_entry(16, 1'b0, slot_pll, word_cfg1_hi, 1'b0);
    // clear cfg2, flag drops
    set_entry(17, 1'b1, slot_pll, word_cfg2_lo, 1'b1);
    set_entry(18, 1'b1, slot_pll, word_cfg2_hi, 1'b1);
    set_entry(19, 1'b0, slot_pll, word_cfg2_hi, 1'b0);
    set_entry(20, 1'b0, slot_pll, word_cfg1_hi, 1'b0);

    seed = 32'h0b0e56cc;
    for (i = 0; i < n_entries; i++) begin
      seed        = next_random(seed);
      tbl_data[i] = tbl_zero[i] ? '0 : seed;
    end
    build_expected();

    repeat (2) @(negedge dev_clk);
    check_reset_state("during reset");
    @(posedge rst_n);
    @(negedge dev_clk);
    check_reset_state("right after reset");

    // core reset on the third edge, monitor toggles every fourth
    for (i = 1; i <= 24; i++) begin
      @(posedge dev_clk);
      @(negedge dev_clk);
      check_value(64'(core_rst_n), 64'(i >= 3), $sformatf("core_rst_n at edge %0d", i));
      check_value(64'(core_clk_out), 64'((i / 4) % 2),
                  $sformatf("core_clk_out at edge %0d", i));
    end

    for (i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    @(posedge dev_clk);
    @(negedge dev_clk);
    check_value(64'(pll_cfg_ctr),
                64'((exp_cfg1[n_entries-1] != '0) && (exp_cfg2[n_entries-1] != '0)),
                "pll_cfg_ctr at end");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/soc_apb_pkg.sv
rtl/pll_cfg_pkg.sv
rtl/apb_slot_decode.sv
rtl/pll_cfg_regs.sv
rtl/core_clk_rst.sv
rtl/soc_ctrl_top.sv
dv/tb_clk_gen.sv
dv/soc_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the SoC control block

VERILATOR ?= verilator
TOP       ?= soc_ctrl_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

FILE_LIST := build.f
SRCS      := $(shell cat $(FILE_LIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
